//--- design/us_acq_macros.svh
`ifndef US_ACQ_MACROS_SVH
`define US_ACQ_MACROS_SVH

// ======================================================================
// front end geometry
// ======================================================================
`define US_NUM_CH          8      // adc channels per board
`define US_ADC_W           14     // raw sample bits
`define US_FIFO_W          16     // padded word toward capture fifo
`define US_COUNT_W         32     // cycle counts
`define US_ADDR_W          3
`define US_DATA_W          32
`define US_CTRL_W          12     // fire + soft reset + board pins
`define US_BOARD_W         10

// fire edge to start strobe, in ADC_CLKOUT cycles
`define US_START_DELAY     10

// ======================================================================
// register map
// ======================================================================
`define US_ADDR_TX_LEN     3'd0
`define US_ADDR_INIT_DELAY 3'd1
`define US_ADDR_SAMPLES    3'd2
`define US_ADDR_CTRL       3'd3

// control word bits
`define US_CTRL_FIRE       0
`define US_CTRL_SOFT_RST   1
`define US_CTRL_BOARD_LSB  2      // board enables live in 11:2

`endif

//--- design/us_acq_pkg.sv
`include "us_acq_macros.svh"

package us_acq_pkg;

	// one raw channel sample straight off the adc
	typedef logic [`US_ADC_W-1:0] adc_sample_t;

	// zero padded word as the capture fifo takes it
	typedef logic [`US_FIFO_W-1:0] fifo_word_t;

	// pulse length, initial delay, samples per echo
	typedef logic [`US_COUNT_W-1:0] acq_count_t;

	// config write port
	typedef logic [`US_ADDR_W-1:0] reg_addr_t;
	typedef logic [`US_DATA_W-1:0] reg_data_t;

	// control word
	// bit 0 fire, bit 1 soft reset
	// bits 11:2 board pins, lsb first:
	//   pulser en, tx buffer oe, adc stby, adc pwdn, adc reset,
	//   mux clk en, then the four supply enables
	typedef logic [`US_CTRL_W-1:0] ctrl_word_t;

	// shot sequencer states
	typedef enum logic [2:0]
	{
		S_IDLE  = 3'd0,  // waiting for start
		S_TX    = 3'd1,  // transmit enable high
		S_DELAY = 3'd2,  // dead time before the window
		S_ACQ   = 3'd3,  // sample window open
		S_DONE  = 3'd4   // one cycle done strobe
	} shot_state_t;

endpackage

//--- design/us_acq_regs.sv
`timescale 1ns/1ps
`include "us_acq_macros.svh"

module us_acq_regs
(
	input  logic                   ADC_CLKOUT,
	input  logic                   rst_n,

	// write port, single cycle strobe
	input  logic                   cfg_wr,
	input  us_acq_pkg::reg_addr_t  cfg_addr,
	input  us_acq_pkg::reg_data_t  cfg_wdata,

	// shot timing
	output us_acq_pkg::acq_count_t tx_len,
	output us_acq_pkg::acq_count_t init_delay,
	output us_acq_pkg::acq_count_t samples,

	// control word fields
	output logic                   fire,
	output logic                   soft_rst,
	output logic [`US_BOARD_W-1:0] board_en
);

	us_acq_pkg::acq_count_t tx_len_q;      // transmit pulse cycles
	us_acq_pkg::acq_count_t init_delay_q;  // cycles from tx end to window
	us_acq_pkg::acq_count_t samples_q;     // window length
	us_acq_pkg::ctrl_word_t ctrl_q;

	// ==================================================================
	// register file
	// ==================================================================
	always_ff @(posedge ADC_CLKOUT)
	begin
		if (!rst_n)
		begin
			tx_len_q     <= '0;
			init_delay_q <= '0;
			samples_q    <= '0;
			ctrl_q       <= '0;  // all board pins off
		end
		else if (cfg_wr)
		begin
			case (cfg_addr)
				`US_ADDR_TX_LEN:     tx_len_q     <= cfg_wdata;
				`US_ADDR_INIT_DELAY: init_delay_q <= cfg_wdata;
				`US_ADDR_SAMPLES:    samples_q    <= cfg_wdata;
				`US_ADDR_CTRL:       ctrl_q       <= cfg_wdata[`US_CTRL_W-1:0];
				default:             ;  // unmapped, dropped
			endcase
		end
	end

	// counts go straight to the sequencer
	assign tx_len     = tx_len_q;
	assign init_delay = init_delay_q;
	assign samples    = samples_q;

	// split control word
	assign fire     = ctrl_q[`US_CTRL_FIRE];      // level, pulser finds the edge
	assign soft_rst = ctrl_q[`US_CTRL_SOFT_RST];  // held until cleared by sw
	assign board_en = ctrl_q[`US_CTRL_W-1:`US_CTRL_BOARD_LSB];

endmodule

//--- design/us_fire_pulser.sv
`timescale 1ns/1ps
`include "us_acq_macros.svh"

module us_fire_pulser
(
	input  logic ADC_CLKOUT,
	input  logic rst_n,
	input  logic soft_rst,
	input  logic fire,   // level from control word
	output logic start   // one cycle strobe
);

	logic                   fire_q;    // previous fire level
	logic                   fire_rise;
	us_acq_pkg::acq_count_t cnt;       // cycles left before start

	// rising edge, only taken when no countdown is pending
	assign fire_rise = fire && !fire_q;

	always_ff @(posedge ADC_CLKOUT)
	begin
		if (!rst_n || soft_rst)
		begin
			fire_q <= 1'b0;
			cnt    <= '0;
			start  <= 1'b0;
		end
		else
		begin
			fire_q <= fire;
			start  <= (cnt == us_acq_pkg::acq_count_t'(1));  // lands on edge + delay

			if (cnt != '0)
			begin
				cnt <= cnt - 1'b1;  // busy, new edges ignored
			end
			else if (fire_rise)
			begin
				// one cycle spent here, the start register takes another
				cnt <= us_acq_pkg::acq_count_t'(`US_START_DELAY - 1);
			end
		end
	end

endmodule

//--- design/us_shot_sequencer.sv
`timescale 1ns/1ps

module us_shot_sequencer
(
	input  logic                   ADC_CLKOUT,
	input  logic                   rst_n,
	input  logic                   soft_rst,
	input  logic                   start,

	input  us_acq_pkg::acq_count_t tx_len,
	input  us_acq_pkg::acq_count_t init_delay,
	input  us_acq_pkg::acq_count_t samples,

	output logic                   tx_en,      // transmit enable pin
	output logic                   fifo_en,    // sample window
	output logic                   acq_last,   // last cycle of the window
	output logic                   shot_done
);

	us_acq_pkg::shot_state_t state;
	us_acq_pkg::acq_count_t  cnt;         // shared down counter, 1 = final cycle
	logic                    last_cycle;

	// zero programmed means one cycle
	function automatic us_acq_pkg::acq_count_t eff_count(input us_acq_pkg::acq_count_t c);
		return (c == '0) ? us_acq_pkg::acq_count_t'(1) : c;
	endfunction

	assign last_cycle = (cnt == us_acq_pkg::acq_count_t'(1));

	// ==================================================================
	// shot fsm
	// ==================================================================
	always_ff @(posedge ADC_CLKOUT)
	begin
		if (!rst_n || soft_rst)
		begin
			state <= us_acq_pkg::S_IDLE;
			cnt   <= '0;
		end
		else
		begin
			case (state)
				us_acq_pkg::S_IDLE:
				begin
					if (start)  // start outside idle is dropped
					begin
						state <= us_acq_pkg::S_TX;
						cnt   <= eff_count(tx_len);
					end
				end

				us_acq_pkg::S_TX:
				begin
					if (last_cycle)
					begin
						state <= us_acq_pkg::S_DELAY;
						cnt   <= eff_count(init_delay);
					end
					else
						cnt <= cnt - 1'b1;
				end

				us_acq_pkg::S_DELAY:
				begin
					if (last_cycle)
					begin
						state <= us_acq_pkg::S_ACQ;
						cnt   <= eff_count(samples);
					end
					else
						cnt <= cnt - 1'b1;
				end

				us_acq_pkg::S_ACQ:
				begin
					if (last_cycle)
					begin
						state <= us_acq_pkg::S_DONE;
						cnt   <= '0;
					end
					else
						cnt <= cnt - 1'b1;
				end

				us_acq_pkg::S_DONE:
					state <= us_acq_pkg::S_IDLE;  // single cycle

				default:
					state <= us_acq_pkg::S_IDLE;
			endcase
		end
	end

	// outputs decoded from state
	assign tx_en     = (state == us_acq_pkg::S_TX);
	assign fifo_en   = (state == us_acq_pkg::S_ACQ);
	assign acq_last  = fifo_en && last_cycle;
	assign shot_done = (state == us_acq_pkg::S_DONE);

endmodule

//--- design/us_channel_framer.sv
`timescale 1ns/1ps
`include "us_acq_macros.svh"

module us_channel_framer
(
	input  logic                                    ADC_CLKOUT,
	input  logic                                    rst_n,
	input  logic                                    soft_rst,

	input  us_acq_pkg::adc_sample_t [`US_NUM_CH-1:0] adc_data,
	input  logic                                    fifo_en,
	input  logic                                    acq_last,

	output us_acq_pkg::fifo_word_t  [`US_NUM_CH-1:0] ch_data,
	output logic                                    ch_valid,
	output logic                                    ch_last,
	output us_acq_pkg::acq_count_t                  sample_idx
);

	us_acq_pkg::acq_count_t idx_cnt;  // index for the next sample in the window

	// sample path, every cycle, two zero msbs
	always_ff @(posedge ADC_CLKOUT)
	begin
		for (int i = 0; i < `US_NUM_CH; i++)
			ch_data[i] <= {{(`US_FIFO_W - `US_ADC_W){1'b0}}, adc_data[i]};
	end

	// window flags follow the data by the same one cycle
	always_ff @(posedge ADC_CLKOUT)
	begin
		if (!rst_n || soft_rst)
		begin
			ch_valid   <= 1'b0;
			ch_last    <= 1'b0;
			sample_idx <= '0;
			idx_cnt    <= '0;
		end
		else
		begin
			ch_valid <= fifo_en;
			ch_last  <= acq_last;
			if (fifo_en)
			begin
				sample_idx <= idx_cnt;
				idx_cnt    <= acq_last ? '0 : idx_cnt + 1'b1;  // next echo from 0
			end
		end
	end

endmodule

//--- design/us_acq_top.sv
`timescale 1ns/1ps
`include "us_acq_macros.svh"

module us_acq_top
(
	input  logic                                    ADC_CLKOUT,
	input  logic                                    rst_n,

	// config write port
	input  logic                                    cfg_wr,
	input  us_acq_pkg::reg_addr_t                   cfg_addr,
	input  us_acq_pkg::reg_data_t                   cfg_wdata,

	// parallel adc samples
	input  us_acq_pkg::adc_sample_t [`US_NUM_CH-1:0] adc_data,

	output logic [`US_BOARD_W-1:0]                  board_en,   // front end and supply pins
	output logic                                    tx_en,
	output logic                                    shot_done,

	// toward capture fifo
	output us_acq_pkg::fifo_word_t  [`US_NUM_CH-1:0] ch_data,
	output logic                                    ch_valid,
	output logic                                    ch_last,
	output us_acq_pkg::acq_count_t                  sample_idx
);

	us_acq_pkg::acq_count_t tx_len;
	us_acq_pkg::acq_count_t init_delay;
	us_acq_pkg::acq_count_t samples;
	logic                   fire;
	logic                   soft_rst;
	logic                   start;     // delayed fire strobe
	logic                   fifo_en;
	logic                   acq_last;

	// ==================================================================
	// control path
	// ==================================================================
	us_acq_regs u_regs
	(
		.ADC_CLKOUT (ADC_CLKOUT),
		.rst_n      (rst_n),
		.cfg_wr     (cfg_wr),
		.cfg_addr   (cfg_addr),
		.cfg_wdata  (cfg_wdata),
		.tx_len     (tx_len),
		.init_delay (init_delay),
		.samples    (samples),
		.fire       (fire),
		.soft_rst   (soft_rst),
		.board_en   (board_en)
	);

	us_fire_pulser u_pulser
	(
		.ADC_CLKOUT (ADC_CLKOUT),
		.rst_n      (rst_n),
		.soft_rst   (soft_rst),
		.fire       (fire),
		.start      (start)
	);

	us_shot_sequencer u_seq
	(
		.ADC_CLKOUT (ADC_CLKOUT),
		.rst_n      (rst_n),
		.soft_rst   (soft_rst),
		.start      (start),
		.tx_len     (tx_len),
		.init_delay (init_delay),
		.samples    (samples),
		.tx_en      (tx_en),
		.fifo_en    (fifo_en),
		.acq_last   (acq_last),
		.shot_done  (shot_done)
	);

	// data path
	us_channel_framer u_framer
	(
		.ADC_CLKOUT (ADC_CLKOUT),
		.rst_n      (rst_n),
		.soft_rst   (soft_rst),
		.adc_data   (adc_data),
		.fifo_en    (fifo_en),
		.acq_last   (acq_last),
		.ch_data    (ch_data),
		.ch_valid   (ch_valid),
		.ch_last    (ch_last),
		.sample_idx (sample_idx)
	);

endmodule

//--- verif/us_acq_properties.sv
`timescale 1ns/1ps

module us_acq_properties
(
	input logic                    ADC_CLKOUT,
	input logic                    rst_n,
	input logic                    soft_rst,
	input logic                    start,
	input us_acq_pkg::shot_state_t state,
	input logic                    tx_en,
	input logic                    fifo_en,
	input logic                    shot_done
);

	// ==================================================================
	// sequencer output rules
	// ==================================================================
	tx_fifo_excl: assert property (@(posedge ADC_CLKOUT) disable iff (!rst_n || soft_rst)
		!(tx_en && fifo_en))
		else $error("tx_en and fifo_en high in the same cycle");

	// done is a strobe
	done_single: assert property (@(posedge ADC_CLKOUT) disable iff (!rst_n)
		shot_done |=> !shot_done)
		else $error("shot_done held longer than one cycle");

	// idle with no start must stay out of the window next cycle
	idle_no_window: assert property (@(posedge ADC_CLKOUT) disable iff (!rst_n || soft_rst)
		(state == us_acq_pkg::S_IDLE && !start) |=> !fifo_en)
		else $error("fifo_en high while the sequencer is idle");

endmodule

bind us_shot_sequencer us_acq_properties u_props
(
	.ADC_CLKOUT (ADC_CLKOUT),
	.rst_n      (rst_n),
	.soft_rst   (soft_rst),
	.start      (start),
	.state      (state),
	.tx_en      (tx_en),
	.fifo_en    (fifo_en),
	.shot_done  (shot_done)
);

//--- verif/us_acq_tb.sv
`timescale 1ns/1ps
`include "us_acq_macros.svh"

module us_acq_tb;

	localparam int N_SHOTS    = 20;
	localparam int MAX_CYCLES = N_SHOTS * 200 + 500;  // worst shot stays well under 200

	logic                                     ADC_CLKOUT = 1'b0;
	logic                                     rst_n;
	logic                                     cfg_wr;
	us_acq_pkg::reg_addr_t                    cfg_addr;
	us_acq_pkg::reg_data_t                    cfg_wdata;
	us_acq_pkg::adc_sample_t [`US_NUM_CH-1:0] adc_data;
	logic [`US_BOARD_W-1:0]                   board_en;
	logic                                     tx_en;
	logic                                     shot_done;
	us_acq_pkg::fifo_word_t  [`US_NUM_CH-1:0] ch_data;
	logic                                     ch_valid;
	logic                                     ch_last;
	us_acq_pkg::acq_count_t                   sample_idx;

	// ==================================================================
	// reference model state
	// ==================================================================
	us_acq_pkg::reg_data_t                    m_tx_len = '0;
	us_acq_pkg::reg_data_t                    m_init = '0;
	us_acq_pkg::reg_data_t                    m_samples = '0;
	us_acq_pkg::ctrl_word_t                   m_ctrl = '0;
	int                                       tx0 = -1000;    // cycle tx_en should rise
	int                                       t_len = 0;
	int                                       d_len = 0;
	int                                       s_len = 0;
	int                                       abort_cyc = -1000;  // outputs forced low from here
	us_acq_pkg::adc_sample_t [`US_NUM_CH-1:0] adc_prev = '0;  // one cycle adc history
	int                                       cyc = 0;
	int                                       errors = 0;
	int                                       checks = 0;

	us_acq_top uut
	(
		.ADC_CLKOUT (ADC_CLKOUT),
		.rst_n      (rst_n),
		.cfg_wr     (cfg_wr),
		.cfg_addr   (cfg_addr),
		.cfg_wdata  (cfg_wdata),
		.adc_data   (adc_data),
		.board_en   (board_en),
		.tx_en      (tx_en),
		.shot_done  (shot_done),
		.ch_data    (ch_data),
		.ch_valid   (ch_valid),
		.ch_last    (ch_last),
		.sample_idx (sample_idx)
	);

	always #4 ADC_CLKOUT = ~ADC_CLKOUT;  // 8 ns period

	// cycle count and run limit
	always @(posedge ADC_CLKOUT)
	begin
		cyc = cyc + 1;
		if (cyc > MAX_CYCLES)
		begin
			$display("timeout, the run did not end within %0d cycles", MAX_CYCLES);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// fresh samples on every channel each cycle
	always @(posedge ADC_CLKOUT)
	begin
		for (int i = 0; i < `US_NUM_CH; i++)
			adc_data[i] <= us_acq_pkg::adc_sample_t'($urandom);
	end

	task automatic log_error(input string msg);
		$display("Error at %0t: %s", $time, msg);
		errors++;
	endtask

	// a programmed zero runs as one cycle
	function automatic int eff(input us_acq_pkg::reg_data_t v);
		return (v == 0) ? 1 : int'(v);
	endfunction

	// ==================================================================
	// per cycle check against the shot timeline
	// ==================================================================
	always @(negedge ADC_CLKOUT)
	begin
		int   a0;     // first S_ACQ cycle
		logic e_tx;
		logic e_valid;
		logic e_end;  // last sample and done share a cycle
		a0      = tx0 + t_len + d_len;
		e_tx    = (cyc >= tx0) && (cyc < tx0 + t_len) && (cyc < abort_cyc);
		e_valid = (cyc > a0) && (cyc <= a0 + s_len) && (cyc < abort_cyc);
		e_end   = (cyc == a0 + s_len) && (cyc < abort_cyc);
		checks++;
		if (tx_en !== e_tx)
			log_error($sformatf("tx_en %b, expected %b", tx_en, e_tx));
		if (ch_valid !== e_valid)
			log_error($sformatf("ch_valid %b, expected %b", ch_valid, e_valid));
		if (ch_last !== e_end)
			log_error($sformatf("ch_last %b, expected %b", ch_last, e_end));
		if (shot_done !== e_end)
			log_error($sformatf("shot_done %b, expected %b", shot_done, e_end));
		if (e_valid && ch_valid)
		begin
			if (sample_idx !== us_acq_pkg::acq_count_t'(cyc - a0 - 1))
				log_error($sformatf("sample_idx %0d, expected %0d", sample_idx, cyc - a0 - 1));
			for (int i = 0; i < `US_NUM_CH; i++)
				if (ch_data[i] !== us_acq_pkg::fifo_word_t'(adc_prev[i]))  // zero extend
					log_error($sformatf("ch_data[%0d] %h, expected %h", i, ch_data[i],
						adc_prev[i]));
		end
		adc_prev = adc_data;
	end

	// strobe write, vis returns the cycle the register shows the data
	task automatic write_reg(input us_acq_pkg::reg_addr_t addr,
		input us_acq_pkg::reg_data_t data, output int vis);
		@(posedge ADC_CLKOUT);
		cfg_wr    <= 1'b1;
		cfg_addr  <= addr;
		cfg_wdata <= data;
		@(posedge ADC_CLKOUT);
		cfg_wr    <= 1'b0;
		cfg_wdata <= us_acq_pkg::reg_data_t'($urandom);  // junk while idle
		case (addr)
			`US_ADDR_TX_LEN:     m_tx_len  = data;
			`US_ADDR_INIT_DELAY: m_init    = data;
			`US_ADDR_SAMPLES:    m_samples = data;
			`US_ADDR_CTRL:       m_ctrl    = us_acq_pkg::ctrl_word_t'(data);
			default:             ;
		endcase
		@(negedge ADC_CLKOUT);
		vis = cyc;
		checks++;
		if (board_en !== m_ctrl[`US_CTRL_W-1:`US_CTRL_BOARD_LSB])
			log_error($sformatf("board_en %h, expected %h", board_en,
				m_ctrl[`US_CTRL_W-1:`US_CTRL_BOARD_LSB]));
	endtask

	task automatic idle_gap();
		repeat ($urandom % 4) @(negedge ADC_CLKOUT);
	endtask

	// fire edge seen at fire_cyc, lay out the expected shot
	task automatic arm_shot(input int fire_cyc);
		tx0       = fire_cyc + `US_START_DELAY + 1;
		t_len     = eff(m_tx_len);
		d_len     = eff(m_init);
		s_len     = eff(m_samples);
		abort_cyc = 1 << 30;
	endtask

	task automatic wait_done(input int shot);
		int n;
		n = 0;
		while (shot_done !== 1'b1 && n < 200)
		begin
			@(negedge ADC_CLKOUT);
			n++;
		end
		if (shot_done !== 1'b1)
		begin
			$display("shot %0d never raised shot_done", shot);
			errors++;
		end
	endtask

	// ==================================================================
	// stimulus
	// ==================================================================
	initial
	begin
		int                    vis;
		int                    off;
		int unsigned           seed_sink;
		us_acq_pkg::reg_data_t board;
		us_acq_pkg::reg_data_t fire_bit;
		us_acq_pkg::reg_data_t srst_bit;
		seed_sink = $urandom(66);  // seeded once for the whole run
		fire_bit  = 32'd1 << `US_CTRL_FIRE;
		srst_bit  = 32'd1 << `US_CTRL_SOFT_RST;
		rst_n     = 1'b0;
		cfg_wr    = 1'b0;
		cfg_addr  = '0;
		cfg_wdata = '0;
		adc_data  = '0;
		repeat (4) @(posedge ADC_CLKOUT);
		rst_n <= 1'b1;
		@(negedge ADC_CLKOUT);
		checks++;
		if (board_en !== '0)
			log_error($sformatf("board_en %h after reset, expected 0", board_en));

		for (int shot = 0; shot < N_SHOTS; shot++)
		begin
			board = us_acq_pkg::reg_data_t'($urandom % 1024) << `US_CTRL_BOARD_LSB;
			write_reg(`US_ADDR_TX_LEN, $urandom % 8, vis);
			idle_gap();
			write_reg(`US_ADDR_INIT_DELAY, $urandom % 16, vis);
			idle_gap();
			// refire shots get a long window so the second start lands mid shot
			if (shot % 5 == 3)
				write_reg(`US_ADDR_SAMPLES, 30 + $urandom % 11, vis);
			else
				write_reg(`US_ADDR_SAMPLES, 1 + $urandom % 40, vis);
			idle_gap();
			if ($urandom % 3 == 0)
				write_reg(us_acq_pkg::reg_addr_t'(4 + $urandom % 4), $urandom, vis);
			write_reg(`US_ADDR_CTRL, board | fire_bit, vis);
			arm_shot(vis);
			if (shot % 5 == 3)
			begin
				while (cyc < tx0)
					@(negedge ADC_CLKOUT);
				write_reg(`US_ADDR_CTRL, board, vis);             // drop fire
				write_reg(`US_ADDR_CTRL, board | fire_bit, vis);  // edge inside the shot
				wait_done(shot);
			end
			else if (shot % 5 == 4)
			begin
				off = $urandom % (t_len + d_len + s_len - 2);
				while (cyc < tx0 + off)
					@(negedge ADC_CLKOUT);
				write_reg(`US_ADDR_CTRL, board | srst_bit, vis);
				abort_cyc = vis + 1;  // pulser, fsm and framer clear on the next edge
				idle_gap();
				write_reg(`US_ADDR_CTRL, board, vis);
				while (cyc <= tx0 + t_len + d_len + s_len + 2)
					@(negedge ADC_CLKOUT);
			end
			else
				wait_done(shot);
			write_reg(`US_ADDR_CTRL, board, vis);  // fire low, ready for the next edge
			idle_gap();
		end

		repeat (30) @(negedge ADC_CLKOUT);  // a stray second shot would show up here
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- us_acq_top.f
+incdir+design
design/us_acq_pkg.sv
design/us_acq_regs.sv
design/us_fire_pulser.sv
design/us_shot_sequencer.sv
design/us_channel_framer.sv
design/us_acq_top.sv
verif/us_acq_properties.sv
verif/us_acq_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= us_acq_tb
SEED      ?= 66
LOG       ?= sim.log
BUILD     ?= obj_dir
FILELIST  ?= us_acq_top.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation into $(LOG) and check it"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP SEED LOG"

test:
	$(VERILATOR) --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1; true
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "test: FAIL"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "test: FAIL, run did not finish"; exit 1; fi
	@echo "test: PASS"

clean:
	rm -rf $(BUILD) $(LOG)
